// File: common/axi_pkg.sv
/* AXI response and burst encodings, burst-size helper */

package axi_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } t_axi_resp;

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } t_axi_burst;

   // AxSIZE code for a full-width beat
   function automatic logic [2:0] size_code(input int unsigned data_w);
      return 3'($clog2(data_w / 8));
   endfunction

endpackage

// File: common/dma_pkg.sv
/* DMA descriptor, control and status types, register map of the CSR port */

package dma_pkg;

   // Descriptor address fields, wide enough for the default bus
   localparam int DESC_ADDR_W = 32;

   // Up to 16 beats per descriptor
   localparam int LENGTH_W = 5;

   localparam int CSR_ADDR_W = 3;
   localparam int DONE_W     = 8;

   typedef struct packed {
      logic [DESC_ADDR_W-1:0] src_addr;
      logic [DESC_ADDR_W-1:0] dest_addr;
      logic [LENGTH_W-1:0]    length;
   } t_dma_descriptor;

   typedef struct packed {
      logic reset_dispatcher;
      logic go;
   } t_dma_csr_control;

   typedef struct packed {
      logic [DONE_W-1:0] done_count;
      logic              queue_full;
      logic              stopped_on_error;
      logic              busy;
   } t_dma_csr_status;

   localparam logic [CSR_ADDR_W-1:0] REG_SRC     = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] REG_DEST    = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] REG_LEN     = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] REG_CONTROL = 3'd3;
   localparam logic [CSR_ADDR_W-1:0] REG_STATUS  = 3'd4;

endpackage

// File: source/dma_fifo.sv
/* Synchronous FIFO with valid/ready on both sides, payload type set by parameter */
`timescale 1ns/1ps

module dma_fifo #(
   parameter type item_t = logic,
   parameter int  DEPTH  = 4
)(
   input  logic  clk,
   input  logic  reset_n,
   input  logic  in_valid,
   input  item_t in_data,
   output logic  in_ready,
   output logic  out_valid,
   output item_t out_data,
   input  logic  out_ready,
   output logic  full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign full      = (count == CNT_W'(DEPTH));
   assign in_ready  = ~full;
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count unchanged
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

endmodule

// File: dma_csr/dma_csr.sv
/* DMA register block. Assembles descriptors from software writes, queues them on go
   and reports engine status and the number of completed copies */
`timescale 1ns/1ps

module dma_csr import dma_pkg::*; #(
   parameter int ADDR_W = 32
)(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  csr_wr,
   input  logic                  csr_rd,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  logic [ADDR_W-1:0]     csr_wdata,
   output logic [ADDR_W-1:0]     csr_rdata,
   output logic                  push_valid,
   output t_dma_descriptor       push_desc,
   input  logic                  push_ready,
   input  logic                  queue_full,
   input  logic                  busy,
   input  logic                  stopped_on_error,
   input  logic                  desc_done,
   output logic                  reset_dispatcher
);

   logic [ADDR_W-1:0]   src_q;
   logic [ADDR_W-1:0]   dest_q;
   logic [LENGTH_W-1:0] len_q;
   logic [DONE_W-1:0]   done_count;
   logic                ctrl_write;
   t_dma_csr_control    ctrl_wr;
   t_dma_csr_status     status;

   assign ctrl_wr    = t_dma_csr_control'(csr_wdata[1:0]);
   assign ctrl_write = csr_wr & (csr_addr == REG_CONTROL);

   // Go on a full queue is dropped
   assign push_valid          = ctrl_write & ctrl_wr.go & push_ready;
   assign push_desc.src_addr  = DESC_ADDR_W'(src_q);
   assign push_desc.dest_addr = DESC_ADDR_W'(dest_q);
   assign push_desc.length    = len_q;

   assign status.done_count       = done_count;
   assign status.queue_full       = queue_full;
   assign status.stopped_on_error = stopped_on_error;
   assign status.busy             = busy;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         src_q            <= '0;
         dest_q           <= '0;
         len_q            <= '0;
         done_count       <= '0;
         reset_dispatcher <= 1'b0;
      end else begin
         if (csr_wr && csr_addr == REG_SRC)  src_q  <= csr_wdata;
         if (csr_wr && csr_addr == REG_DEST) dest_q <= csr_wdata;
         if (csr_wr && csr_addr == REG_LEN)  len_q  <= csr_wdata[LENGTH_W-1:0];
         reset_dispatcher <= ctrl_write & ctrl_wr.reset_dispatcher;
         if (desc_done) done_count <= done_count + 1'b1;
      end
   end

   // Read data one cycle after the strobe
   always_ff @(posedge clk) begin
      if (csr_rd) begin
         case (csr_addr)
            REG_SRC:    csr_rdata <= src_q;
            REG_DEST:   csr_rdata <= dest_q;
            REG_LEN:    csr_rdata <= ADDR_W'(len_q);
            REG_STATUS: csr_rdata <= ADDR_W'(status);
            default:    csr_rdata <= '0;
         endcase
      end
   end

endmodule

// File: dma_engine/read_source_fsm.sv
/* Source read engine. One INCR read burst per descriptor, beats go straight into
   the data FIFO */
`timescale 1ns/1ps

module read_source_fsm import dma_pkg::*, axi_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 64
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              desc_valid,
   input  t_dma_descriptor   desc,
   input  logic              desc_ready,
   output logic              arvalid,
   output logic [ADDR_W-1:0] araddr,
   output logic [7:0]        arlen,
   output logic [2:0]        arsize,
   output logic [1:0]        arburst,
   input  logic              arready,
   input  logic              rvalid,
   input  logic [DATA_W-1:0] rdata,
   input  logic              rlast,
   output logic              rready,
   output logic              data_valid,
   output logic [DATA_W-1:0] data,
   input  logic              data_ready
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR_SETUP,
      READ_DATA
   } t_state;

   t_state state;
   logic   started;
   logic   start;
   logic   beat_done;

   // Head stays in the queue until the write side finishes, so read it only once
   assign start = (state == IDLE) & desc_valid & ~started;

   assign arsize  = size_code(DATA_W);
   assign arburst = INCR;

   assign rready     = (state == READ_DATA) & data_ready;
   assign data_valid = (state == READ_DATA) & rvalid;
   assign data       = rdata;
   assign beat_done  = rvalid & rready;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state   <= IDLE;
         arvalid <= 1'b0;
         started <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state   <= ADDR_SETUP;
                  arvalid <= 1'b1;
                  started <= 1'b1;
               end
            end
            ADDR_SETUP: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  state   <= READ_DATA;
               end
            end
            READ_DATA: begin
               if (beat_done && rlast) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
         // Descriptor retired by the write engine
         if (desc_valid && desc_ready) started <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         araddr <= ADDR_W'(desc.src_addr);
         arlen  <= 8'(desc.length) - 8'd1;
      end
   end

endmodule

// File: dma_engine/write_dest_fsm.sv
/* Destination write engine. Drains the data FIFO into one INCR write burst, checks
   the write response and holds the error state until software clears it */
`timescale 1ns/1ps

module write_dest_fsm import dma_pkg::*, axi_pkg::*; #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 64
)(
   input  logic                clk,
   input  logic                reset_n,
   input  logic                desc_valid,
   input  t_dma_descriptor     desc,
   output logic                desc_ready,
   input  logic                reset_dispatcher,
   output logic                awvalid,
   output logic [ADDR_W-1:0]   awaddr,
   output logic [7:0]          awlen,
   output logic [2:0]          awsize,
   output logic [1:0]          awburst,
   input  logic                awready,
   output logic                wvalid,
   output logic [DATA_W-1:0]   wdata,
   output logic                wlast,
   output logic [DATA_W/8-1:0] wstrb,
   input  logic                wready,
   input  logic                bvalid,
   input  logic [1:0]          bresp,
   output logic                bready,
   input  logic                data_valid,
   input  logic [DATA_W-1:0]   data,
   output logic                data_ready,
   output logic                busy,
   output logic                stopped_on_error,
   output logic                desc_done
);

   typedef enum int {
      IDLE_BIT,
      ADDR_SETUP_BIT,
      WRITE_DATA_BIT,
      WAIT_FOR_WR_RSP_BIT,
      ERROR_BIT
   } t_state_bit;

   typedef enum logic [4:0] {
      IDLE            = 5'b1 << IDLE_BIT,
      ADDR_SETUP      = 5'b1 << ADDR_SETUP_BIT,
      WRITE_DATA      = 5'b1 << WRITE_DATA_BIT,
      WAIT_FOR_WR_RSP = 5'b1 << WAIT_FOR_WR_RSP_BIT,
      ERROR           = 5'b1 << ERROR_BIT
   } t_state;

   t_state              state;
   t_state              next;
   logic [LENGTH_W-1:0] pop_cnt;
   logic                pop;
   logic                wr_resp;
   logic                resp_err;

   assign awsize  = size_code(DATA_W);
   assign awburst = INCR;
   assign wstrb   = '1;

   // Pop only into an empty or draining output slot, never past the burst length
   assign pop = state[WRITE_DATA_BIT] & data_valid & (pop_cnt != desc.length)
              & (~wvalid | wready);
   assign data_ready = pop;

   assign wr_resp  = bvalid & bready;
   assign resp_err = (bresp == SLVERR) | (bresp == DECERR);
   assign bready   = state[WAIT_FOR_WR_RSP_BIT];

   assign desc_done  = wr_resp & ~resp_err;
   assign desc_ready = desc_done | (state[ERROR_BIT] & reset_dispatcher);

   assign busy             = ~state[IDLE_BIT] & ~state[ERROR_BIT];
   assign stopped_on_error = state[ERROR_BIT];

   always_comb begin
      next = state;
      unique case (1'b1)
         state[IDLE_BIT]:            if (desc_valid) next = ADDR_SETUP;
         state[ADDR_SETUP_BIT]:      if (awready) next = WRITE_DATA;
         state[WRITE_DATA_BIT]:      if (wvalid && wready && wlast) next = WAIT_FOR_WR_RSP;
         state[WAIT_FOR_WR_RSP_BIT]: if (wr_resp) next = resp_err ? ERROR : IDLE;
         state[ERROR_BIT]:           if (reset_dispatcher) next = IDLE;
         default:                    next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state   <= IDLE;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         pop_cnt <= '0;
      end else begin
         state <= next;
         if (state[IDLE_BIT] && desc_valid) begin
            awvalid <= 1'b1;
            pop_cnt <= '0;
         end else if (state[ADDR_SETUP_BIT] && awready) begin
            awvalid <= 1'b0;
         end
         if (pop) begin
            wvalid  <= 1'b1;
            pop_cnt <= pop_cnt + 1'b1;
         end else if (wready) begin
            wvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state[IDLE_BIT] && desc_valid) begin
         awaddr <= ADDR_W'(desc.dest_addr);
         awlen  <= 8'(desc.length) - 8'd1;
      end
      if (pop) begin
         wdata <= data;
         wlast <= (pop_cnt == desc.length - 1'b1);
      end
   end

endmodule

// File: source/dma_top.sv
/* Single-channel memory-to-memory DMA. Register block, descriptor queue, read and
   write engines joined by the data FIFO */
`timescale 1ns/1ps

module dma_top import dma_pkg::*; #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 64,
   parameter int DESC_DEPTH = 4,
   parameter int DATA_DEPTH = 16
)(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  csr_wr,
   input  logic                  csr_rd,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  logic [ADDR_W-1:0]     csr_wdata,
   output logic [ADDR_W-1:0]     csr_rdata,
   output logic                  arvalid,
   output logic [ADDR_W-1:0]     araddr,
   output logic [7:0]            arlen,
   output logic [2:0]            arsize,
   output logic [1:0]            arburst,
   input  logic                  arready,
   input  logic                  rvalid,
   input  logic [DATA_W-1:0]     rdata,
   input  logic                  rlast,
   input  logic [1:0]            rresp,   // Read response is not checked
   output logic                  rready,
   output logic                  awvalid,
   output logic [ADDR_W-1:0]     awaddr,
   output logic [7:0]            awlen,
   output logic [2:0]            awsize,
   output logic [1:0]            awburst,
   input  logic                  awready,
   output logic                  wvalid,
   output logic [DATA_W-1:0]     wdata,
   output logic                  wlast,
   output logic [DATA_W/8-1:0]   wstrb,
   input  logic                  wready,
   input  logic                  bvalid,
   input  logic [1:0]            bresp,
   output logic                  bready
);

   t_dma_descriptor   push_desc;
   t_dma_descriptor   desc;
   logic              push_valid;
   logic              push_ready;
   logic              queue_full;
   logic              desc_valid;
   logic              desc_ready;
   logic              busy;
   logic              stopped_on_error;
   logic              desc_done;
   logic              reset_dispatcher;
   logic              in_valid;
   logic [DATA_W-1:0] in_data;
   logic              in_ready;
   logic              out_valid;
   logic [DATA_W-1:0] out_data;
   logic              out_ready;

   dma_csr #(.ADDR_W(ADDR_W)) u_csr (
      .clk, .reset_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
      .push_valid, .push_desc, .push_ready, .queue_full,
      .busy, .stopped_on_error, .desc_done, .reset_dispatcher
   );

   dma_fifo #(.item_t(t_dma_descriptor), .DEPTH(DESC_DEPTH)) u_desc_queue (
      .clk, .reset_n,
      .in_valid(push_valid), .in_data(push_desc), .in_ready(push_ready),
      .out_valid(desc_valid), .out_data(desc), .out_ready(desc_ready),
      .full(queue_full)
   );

   read_source_fsm #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_read (
      .clk, .reset_n, .desc_valid, .desc, .desc_ready,
      .arvalid, .araddr, .arlen, .arsize, .arburst, .arready,
      .rvalid, .rdata, .rlast, .rready,
      .data_valid(in_valid), .data(in_data), .data_ready(in_ready)
   );

   dma_fifo #(.item_t(logic [DATA_W-1:0]), .DEPTH(DATA_DEPTH)) u_data_fifo (
      .clk, .reset_n,
      .in_valid, .in_data, .in_ready,
      .out_valid, .out_data, .out_ready,
      .full()
   );

   write_dest_fsm #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_write (
      .clk, .reset_n, .desc_valid, .desc, .desc_ready, .reset_dispatcher,
      .awvalid, .awaddr, .awlen, .awsize, .awburst, .awready,
      .wvalid, .wdata, .wlast, .wstrb, .wready,
      .bvalid, .bresp, .bready,
      .data_valid(out_valid), .data(out_data), .data_ready(out_ready),
      .busy, .stopped_on_error, .desc_done
   );

endmodule

// File: test/axi_mem_model.sv
/* Behavioral AXI memory for the DMA testbench. Random handshake gaps, SLVERR on
   writes whose address has the top bit set */
`timescale 1ns/1ps

module axi_mem_model import axi_pkg::*; #(
   parameter int ADDR_W    = 32,
   parameter int DATA_W    = 64,
   parameter int MEM_WORDS = 1024
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              hold,
   input  logic              arvalid,
   input  logic [ADDR_W-1:0] araddr,
   input  logic [7:0]        arlen,
   output logic              arready,
   output logic              rvalid,
   output logic [DATA_W-1:0] rdata,
   output logic              rlast,
   output logic [1:0]        rresp,
   input  logic              rready,
   input  logic              awvalid,
   input  logic [ADDR_W-1:0] awaddr,
   output logic              awready,
   input  logic              wvalid,
   input  logic [DATA_W-1:0] wdata,
   input  logic              wlast,
   output logic              wready,
   output logic              bvalid,
   output logic [1:0]        bresp,
   input  logic              bready
);

   localparam int OFFSET_W = $clog2(DATA_W / 8);

   logic [DATA_W-1:0] mem [MEM_WORDS];
   integer            seed = 32'h0f1ab0ea;
   int                rd_idx;
   int                rd_left;
   int                wr_idx;
   logic              wr_active;
   logic              wr_err;
   logic              b_pend;
   logic              r_held;
   logic              b_held;
   logic              live;
   logic              stall;

   function automatic int word_index(input logic [ADDR_W-1:0] addr);
      return int'((addr >> OFFSET_W) % MEM_WORDS);
   endfunction

   // Three cycles in four offer a handshake
   function automatic logic coin();
      return ($random(seed) & 3) != 0;
   endfunction

   assign rresp = OKAY;

   initial begin
      arready   = 1'b0;
      rvalid    = 1'b0;
      rdata     = '0;
      rlast     = 1'b0;
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      bresp     = OKAY;
      rd_left   = 0;
      wr_active = 1'b0;
      wr_err    = 1'b0;
      b_pend    = 1'b0;
   end

   always @(posedge clk) begin
      live   = reset_n;
      stall  = hold;
      r_held = rvalid & ~rready;
      b_held = bvalid & ~bready;
      if (!live) begin
         rd_left   = 0;
         wr_active = 1'b0;
         b_pend    = 1'b0;
         r_held    = 1'b0;
         b_held    = 1'b0;
      end else begin
         if (arvalid && arready) begin
            rd_idx  = word_index(araddr);
            rd_left = int'(arlen) + 1;
         end
         if (rvalid && rready) begin
            rd_idx  = (rd_idx + 1) % MEM_WORDS;
            rd_left = rd_left - 1;
         end
         if (awvalid && awready) begin
            wr_idx    = word_index(awaddr);
            wr_err    = awaddr[ADDR_W-1];
            wr_active = 1'b1;
         end
         if (wvalid && wready) begin
            // Error range is never written
            if (!wr_err) mem[wr_idx] = wdata;
            wr_idx = (wr_idx + 1) % MEM_WORDS;
            if (wlast) begin
               wr_active = 1'b0;
               b_pend    = 1'b1;
            end
         end
         if (bvalid && bready) b_pend = 1'b0;
      end
      #1;
      arready = live & ~stall & (rd_left == 0) & coin();
      rvalid  = live & (r_held | ((rd_left != 0) & ~stall & coin()));
      rdata   = mem[rd_idx];
      rlast   = (rd_left == 1);
      awready = live & ~stall & ~wr_active & ~b_pend & coin();
      wready  = live & ~stall & wr_active & coin();
      bvalid  = live & (b_held | (b_pend & ~stall & coin()));
      bresp   = wr_err ? SLVERR : OKAY;
   end

endmodule

// File: test/dma_asserts.sv
/* AXI channel checks bound into the DMA top level */
`timescale 1ns/1ps

module dma_asserts #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 64
)(
   input logic              clk,
   input logic              reset_n,
   input logic              arvalid,
   input logic [ADDR_W-1:0] araddr,
   input logic [7:0]        arlen,
   input logic              arready,
   input logic              awvalid,
   input logic [ADDR_W-1:0] awaddr,
   input logic [7:0]        awlen,
   input logic              awready,
   input logic              wvalid,
   input logic [DATA_W-1:0] wdata,
   input logic              wlast,
   input logic              wready
);

   logic       reset_seen = 1'b0;
   logic [7:0] beat_cnt;
   logic [7:0] burst_len;
   int         failures = 0;

   always @(posedge clk) begin
      reset_seen <= ~reset_n;
      if (!reset_n) begin
         beat_cnt <= '0;
      end else begin
         if (awvalid && awready) burst_len <= awlen;
         if (wvalid && wready) beat_cnt <= wlast ? 8'd0 : beat_cnt + 8'd1;
      end
   end

   ar_stable: assert property (@(posedge clk) disable iff (!reset_n)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
      else begin
         failures++;
         $error("AR payload changed while waiting for arready");
      end

   aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
      else begin
         failures++;
         $error("AW payload changed while waiting for awready");
      end

   w_stable: assert property (@(posedge clk) disable iff (!reset_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
      else begin
         failures++;
         $error("W payload changed while waiting for wready");
      end

   // Last beat is beat number awlen of the burst
   wlast_at_end: assert property (@(posedge clk) disable iff (!reset_n)
      wvalid && wready |-> wlast == (beat_cnt == burst_len))
      else begin
         failures++;
         $error("wlast does not match the end of the burst");
      end

   no_valid_in_reset: assert property (@(posedge clk)
      reset_seen && !reset_n |-> !arvalid && !awvalid && !wvalid)
      else begin
         failures++;
         $error("AXI valid high during reset");
      end

endmodule

bind dma_top dma_asserts #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_asserts (.*);

// File: test/tb_dma_top.sv
/* Testbench for the DMA top level. Directed copies through the register port
   against a behavioral AXI memory */
`timescale 1ns/1ps

module tb_dma_top import dma_pkg::*; ();

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 64;
   localparam int DESC_DEPTH = 4;
   localparam int DATA_DEPTH = 16;
   localparam int MEM_WORDS  = 1024;
   localparam int BEAT_BYTES = DATA_W / 8;
   localparam int CLK_PERIOD = 8;
   // Watchdog allows 200 cycles per beat of all tests together
   localparam int TOTAL_BEATS = 16 + (8 + 16 + 5) + (DESC_DEPTH + 1) * 4 + 2 * 4;
   localparam int TIMEOUT_NS  = TOTAL_BEATS * 200 * CLK_PERIOD;
   localparam logic [31:0] SRC_TAG  = 32'h5a5a_0f0f;
   localparam logic [31:0] DEST_TAG = 32'hc3c3_7e7e;

   logic                  clk;
   logic                  reset_n;
   logic                  hold;
   logic                  csr_wr;
   logic                  csr_rd;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [ADDR_W-1:0]     csr_wdata;
   logic [ADDR_W-1:0]     csr_rdata;
   logic                  arvalid;
   logic [ADDR_W-1:0]     araddr;
   logic [7:0]            arlen;
   logic [2:0]            arsize;
   logic [1:0]            arburst;
   logic                  arready;
   logic                  rvalid;
   logic [DATA_W-1:0]     rdata;
   logic                  rlast;
   logic [1:0]            rresp;
   logic                  rready;
   logic                  awvalid;
   logic [ADDR_W-1:0]     awaddr;
   logic [7:0]            awlen;
   logic [2:0]            awsize;
   logic [1:0]            awburst;
   logic                  awready;
   logic                  wvalid;
   logic [DATA_W-1:0]     wdata;
   logic                  wlast;
   logic [DATA_W/8-1:0]   wstrb;
   logic                  wready;
   logic                  bvalid;
   logic [1:0]            bresp;
   logic                  bready;

   // Last address phase seen on each channel
   logic [ADDR_W-1:0] seen_araddr;
   logic [ADDR_W-1:0] seen_awaddr;
   logic [7:0]        seen_arlen;
   logic [7:0]        seen_awlen;
   logic [2:0]        seen_arsize;
   logic [2:0]        seen_awsize;
   logic [1:0]        seen_arburst;
   logic [1:0]        seen_awburst;

   int         errors;
   int         tests_run;
   logic [7:0] done_expected;

   dma_top #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .DESC_DEPTH(DESC_DEPTH), .DATA_DEPTH(DATA_DEPTH)
   ) DUT (.*);

   axi_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_WORDS(MEM_WORDS)) u_mem (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      if (arvalid && arready) begin
         seen_araddr  <= araddr;
         seen_arlen   <= arlen;
         seen_arsize  <= arsize;
         seen_arburst <= arburst;
      end
      if (awvalid && awready) begin
         seen_awaddr  <= awaddr;
         seen_awlen   <= awlen;
         seen_awsize  <= awsize;
         seen_awburst <= awburst;
      end
      // Every write beat carries all byte lanes
      if (wvalid && wready && wstrb !== '1)
         report_mismatch($sformatf("wstrb %h on a write beat", wstrb));
   end

   function automatic logic [DATA_W-1:0] pattern(input logic [31:0] tag,
                                                 input logic [31:0] addr);
      return {tag ^ addr, ~addr};
   endfunction

   function automatic int word_index(input logic [ADDR_W-1:0] addr);
      return int'((addr / BEAT_BYTES) % MEM_WORDS);
   endfunction

   task automatic report_mismatch(input string msg);
      errors++;
      $display("Fail %0t ns: %s", $time, msg);
   endtask

   // Lower half holds source data, upper half starts as a known filler
   task automatic fill_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (i < MEM_WORDS / 2) u_mem.mem[i] = pattern(SRC_TAG, 32'(i * BEAT_BYTES));
         else u_mem.mem[i] = pattern(DEST_TAG, 32'(i * BEAT_BYTES));
      end
   endtask

   // Register tasks start and end 1 ns after a rising edge
   task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [ADDR_W-1:0] value);
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = value;
      @(posedge clk);
      #1;
      csr_wr = 1'b0;
   endtask

   task automatic read_status(output t_dma_csr_status st);
      csr_rd   = 1'b1;
      csr_addr = REG_STATUS;
      @(posedge clk);
      #1;
      csr_rd = 1'b0;
      st     = t_dma_csr_status'(csr_rdata[$bits(t_dma_csr_status)-1:0]);
   endtask

   task automatic start_copy(input logic [31:0] src, input logic [31:0] dest, input int len);
      t_dma_csr_control ctl;
      ctl    = '0;
      ctl.go = 1'b1;
      csr_write(REG_SRC, src);
      csr_write(REG_DEST, dest);
      csr_write(REG_LEN, ADDR_W'(len));
      csr_write(REG_CONTROL, ADDR_W'(ctl));
   endtask

   task automatic wait_copies(input logic [7:0] target, output t_dma_csr_status st);
      do begin
         read_status(st);
      end while (st.done_count != target && !st.stopped_on_error);
   endtask

   task automatic check_region(input logic [31:0] src, input logic [31:0] dest, input int len);
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] exp;
      for (int i = 0; i < len; i++) begin
         exp = pattern(SRC_TAG, src + i * BEAT_BYTES);
         got = u_mem.mem[word_index(dest + i * BEAT_BYTES)];
         if (got !== exp)
            report_mismatch($sformatf("dest %h beat %0d is %h, expected %h", dest, i, got, exp));
      end
   endtask

   task automatic check_burst(input logic [31:0] src, input logic [31:0] dest, input int len);
      if (seen_araddr != src || seen_awaddr != dest)
         report_mismatch($sformatf("burst addresses %h/%h", seen_araddr, seen_awaddr));
      if (seen_arlen != 8'(len - 1) || seen_awlen != 8'(len - 1))
         report_mismatch($sformatf("arlen %0d awlen %0d", seen_arlen, seen_awlen));
      // A full-width beat moves 2**size bytes
      if ((1 << seen_arsize) !== BEAT_BYTES || (1 << seen_awsize) !== BEAT_BYTES)
         report_mismatch($sformatf("arsize %0d awsize %0d", seen_arsize, seen_awsize));
      // AXI INCR encoding
      if (seen_arburst != 2'b01 || seen_awburst != 2'b01)
         report_mismatch($sformatf("burst types %b/%b", seen_arburst, seen_awburst));
   endtask

   task automatic test_reset_state();
      t_dma_csr_status st;
      tests_run++;
      if (arvalid || awvalid || wvalid) report_mismatch("AXI valid high after reset");
      read_status(st);
      if (st.busy || st.stopped_on_error || st.done_count != 8'd0)
         report_mismatch($sformatf("status after reset is %h", st));
   endtask

   task automatic test_single_copy();
      t_dma_csr_status st;
      tests_run++;
      start_copy(32'h0000, 32'h1000, 16);
      done_expected++;
      wait_copies(done_expected, st);
      if (st.done_count != done_expected || st.stopped_on_error)
         report_mismatch($sformatf("single copy status %h", st));
      check_burst(32'h0000, 32'h1000, 16);
      check_region(32'h0000, 32'h1000, 16);
   endtask

   task automatic test_queued_copies();
      t_dma_csr_status st;
      tests_run++;
      start_copy(32'h0100, 32'h1100, 8);
      start_copy(32'h0200, 32'h1200, 16);
      start_copy(32'h0300, 32'h1300, 5);
      done_expected += 8'd3;
      wait_copies(done_expected, st);
      if (st.done_count != done_expected || st.stopped_on_error)
         report_mismatch($sformatf("queued copies status %h", st));
      check_region(32'h0100, 32'h1100, 8);
      check_region(32'h0200, 32'h1200, 16);
      check_region(32'h0300, 32'h1300, 5);
   endtask

   task automatic test_queue_full();
      t_dma_csr_status st;
      logic [31:0]     last_dest;
      tests_run++;
      hold = 1'b1;
      for (int i = 0; i <= DESC_DEPTH; i++) begin
         start_copy(32'h0400 + i * 32'h40, 32'h1400 + i * 32'h40, 4);
      end
      read_status(st);
      if (!st.queue_full) report_mismatch("queue_full not set with the memory stalled");
      hold = 1'b0;
      done_expected += 8'(DESC_DEPTH);
      wait_copies(done_expected, st);
      // Give a dropped descriptor time to show up as an extra copy
      repeat (100) @(posedge clk);
      #1;
      read_status(st);
      if (st.done_count != done_expected || st.busy || st.queue_full)
         report_mismatch($sformatf("queue full status %h", st));
      for (int i = 0; i < DESC_DEPTH; i++) begin
         check_region(32'h0400 + i * 32'h40, 32'h1400 + i * 32'h40, 4);
      end
      last_dest = 32'h1400 + DESC_DEPTH * 32'h40;
      if (u_mem.mem[word_index(last_dest)] !== pattern(DEST_TAG, last_dest))
         report_mismatch("dropped descriptor wrote its destination");
   endtask

   task automatic test_error_recovery();
      t_dma_csr_status  st;
      t_dma_csr_control ctl;
      tests_run++;
      start_copy(32'h0600, 32'h8000_1800, 4);
      wait_copies(done_expected + 8'd1, st);
      if (!st.stopped_on_error || st.done_count != done_expected)
         report_mismatch($sformatf("status after write error %h", st));
      ctl                  = '0;
      ctl.reset_dispatcher = 1'b1;
      csr_write(REG_CONTROL, ADDR_W'(ctl));
      // Error state leaves one cycle after the pulse
      @(posedge clk);
      #1;
      read_status(st);
      if (st.stopped_on_error) report_mismatch("stopped_on_error still set after reset_dispatcher");
      start_copy(32'h0680, 32'h1800, 4);
      done_expected++;
      wait_copies(done_expected, st);
      if (st.done_count != done_expected || st.stopped_on_error)
         report_mismatch($sformatf("copy after recovery status %h", st));
      check_region(32'h0680, 32'h1800, 4);
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, the DMA copies did not finish", TIMEOUT_NS);
      $display("Tests run: %0d, errors: %0d", tests_run, errors);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      clk           = 1'b0;
      reset_n       = 1'b0;
      hold          = 1'b0;
      csr_wr        = 1'b0;
      csr_rd        = 1'b0;
      csr_addr      = '0;
      csr_wdata     = '0;
      errors        = 0;
      tests_run     = 0;
      done_expected = '0;
      fill_memory();
      repeat (8) @(posedge clk);
      #1;
      reset_n = 1'b1;
      test_reset_state();
      test_single_copy();
      test_queued_copies();
      test_queue_full();
      test_error_recovery();
      errors += DUT.u_asserts.failures;
      $display("Tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: sim.f
common/axi_pkg.sv
common/dma_pkg.sv
source/dma_fifo.sv
dma_csr/dma_csr.sv
dma_engine/read_source_fsm.sv
dma_engine/write_dest_fsm.sv
source/dma_top.sv
test/axi_mem_model.sv
test/dma_asserts.sv
test/tb_dma_top.sv

// File: Bender.yml
package:
  name: dma

sources:
  - common/axi_pkg.sv
  - common/dma_pkg.sv
  - source/dma_fifo.sv
  - dma_csr/dma_csr.sv
  - dma_engine/read_source_fsm.sv
  - dma_engine/write_dest_fsm.sv
  - source/dma_top.sv
  - target: test
    files:
      - test/axi_mem_model.sv
      - test/dma_asserts.sv
      - test/tb_dma_top.sv
